// ==== saturn_alu_settings.svh ====
`ifndef SATURN_ALU_SETTINGS_SVH
`define SATURN_ALU_SETTINGS_SVH

// one hex digit
`define SATURN_NIBBLE_W 4

// A, B, C and D are 16 digits wide
`define SATURN_WORD_NIBBLES 16

// D0 and D1 are 5 digits wide
`define SATURN_ADDR_NIBBLES 5

// nibble index inside a working register
`define SATURN_FIELD_W 4

// opcode and register select widths
`define SATURN_OP_W 5
`define SATURN_REG_W 5

`endif

// ==== saturn_alu_pkg.sv ====
`default_nettype none

`include "saturn_alu_settings.svh"

package saturn_alu_pkg;

  typedef logic [`SATURN_NIBBLE_W-1:0] nibble_t;
  typedef logic [`SATURN_NIBBLE_W*`SATURN_WORD_NIBBLES-1:0] word_t;
  typedef logic [`SATURN_FIELD_W-1:0] field_idx_t;

  typedef enum logic [`SATURN_OP_W-1:0] {
    ALU_OP_ZERO     = 5'd0,
    ALU_OP_COPY     = 5'd1,
    ALU_OP_EXCH     = 5'd2,
    ALU_OP_2CMPL    = 5'd5,
    ALU_OP_ADD      = 5'd10,
    ALU_OP_CLR_MASK = 5'd14
  } alu_op_e;

  // IMM and ZERO are source-only selects
  typedef enum logic [`SATURN_REG_W-1:0] {
    ALU_REG_A    = 5'd0,
    ALU_REG_B    = 5'd1,
    ALU_REG_C    = 5'd2,
    ALU_REG_D    = 5'd3,
    ALU_REG_D0   = 5'd4,
    ALU_REG_D1   = 5'd5,
    ALU_REG_IMM  = 5'd30,
    ALU_REG_ZERO = 5'd31
  } alu_reg_e;

  typedef struct packed {
    alu_op_e    op;
    alu_reg_e   dest;
    alu_reg_e   src1;
    alu_reg_e   src2;
    field_idx_t first;
    field_idx_t last;
  } alu_cmd_t;

  typedef struct packed {
    field_idx_t cur;
    logic       is_first;
    logic       is_last;
  } field_state_t;

  typedef struct packed {
    logic prep;
    logic calc;
    logic save;
  } phase_t;

  typedef struct packed {
    nibble_t src1;
    nibble_t src2;
  } operand_t;

  // carry holds the chained carry for ADD, the nonzero flag for 2CMPL
  typedef struct packed {
    nibble_t res1;
    nibble_t res2;
    logic    carry;
  } result_t;

  typedef struct packed {
    word_t                                           a;
    word_t                                           b;
    word_t                                           c;
    word_t                                           d;
    logic [`SATURN_NIBBLE_W*`SATURN_ADDR_NIBBLES-1:0] d0;
    logic [`SATURN_NIBBLE_W*`SATURN_ADDR_NIBBLES-1:0] d1;
  } reg_view_t;

endpackage

`default_nettype wire

// ==== saturn_alu_cmd_latch.sv ====
`timescale 1ns/10ps
`default_nettype none

module saturn_alu_cmd_latch
  import saturn_alu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset,
  input  logic         i_en_alu_init,
  input  logic         i_en_alu_prep,
  input  logic         i_en_alu_calc,
  input  logic         i_en_alu_save,
  input  logic         i_ins_alu_op,
  input  alu_op_e      i_alu_op,
  input  alu_reg_e     i_reg_dest,
  input  alu_reg_e     i_reg_src1,
  input  alu_reg_e     i_reg_src2,
  input  field_idx_t   i_field_start,
  input  field_idx_t   i_field_last,
  output alu_cmd_t     o_cmd,
  output field_state_t o_field,
  output phase_t       o_phase,
  output logic         o_busy
);

  logic       busy_q;
  alu_cmd_t   cmd_q;
  field_idx_t cur_q;
  logic       accept;

  // a new instruction is only taken while idle
  assign accept = i_en_alu_init && i_ins_alu_op && !busy_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy_q <= 1'b0;
      cur_q  <= '0;
      cmd_q  <= alu_cmd_t'('0);
    end else if (accept) begin
      busy_q <= 1'b1;
      cur_q  <= i_field_start;
      cmd_q  <= '{i_alu_op, i_reg_dest, i_reg_src1, i_reg_src2,
                  i_field_start, i_field_last};
    end else if (o_phase.save) begin
      // pointer wraps from 15 back to 0
      cur_q <= cur_q + 1'b1;
      if (o_field.is_last) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign o_field.cur      = cur_q;
  assign o_field.is_first = (cur_q == cmd_q.first);
  assign o_field.is_last  = (cur_q == cmd_q.last);

  // strobes outside an instruction are dropped here
  assign o_phase.prep = i_en_alu_prep && busy_q;
  assign o_phase.calc = i_en_alu_calc && busy_q;
  assign o_phase.save = i_en_alu_save && busy_q;

  assign o_cmd  = cmd_q;
  assign o_busy = busy_q;

endmodule

`default_nettype wire

// ==== saturn_alu_operand_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "saturn_alu_settings.svh"

module saturn_alu_operand_fetch
  import saturn_alu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset,
  input  phase_t       i_phase,
  input  alu_cmd_t     i_cmd,
  input  field_state_t i_field,
  input  reg_view_t    i_regs,
  input  nibble_t      i_imm_value,
  output operand_t     o_operand
);

  operand_t operand_q;
  logic     need_src2;

  // returns one digit of a source, address registers read zero above their top
  function automatic nibble_t pick_nibble(input alu_reg_e sel, input reg_view_t regs,
                                          input field_idx_t idx, input nibble_t imm);
    word_t   w;
    nibble_t n;
    w = '0;
    case (sel)
      ALU_REG_A:  w = regs.a;
      ALU_REG_B:  w = regs.b;
      ALU_REG_C:  w = regs.c;
      ALU_REG_D:  w = regs.d;
      ALU_REG_D0: w = word_t'(regs.d0);
      ALU_REG_D1: w = word_t'(regs.d1);
      default:    w = '0;
    endcase
    n = w[idx*`SATURN_NIBBLE_W +: `SATURN_NIBBLE_W];
    if (sel == ALU_REG_IMM) begin
      n = imm;
    end
    return n;
  endfunction

  // only the two-operand ops look at src2
  assign need_src2 = (i_cmd.op == ALU_OP_EXCH) || (i_cmd.op == ALU_OP_ADD) ||
                     (i_cmd.op == ALU_OP_CLR_MASK);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      operand_q <= '0;
    end else if (i_phase.prep) begin
      operand_q.src1 <= pick_nibble(i_cmd.src1, i_regs, i_field.cur, i_imm_value);
      if (need_src2) begin
        operand_q.src2 <= pick_nibble(i_cmd.src2, i_regs, i_field.cur, i_imm_value);
      end
    end
  end

  assign o_operand = operand_q;

endmodule

`default_nettype wire

// ==== saturn_alu_nibble_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "saturn_alu_settings.svh"

module saturn_alu_nibble_calc
  import saturn_alu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset,
  input  phase_t       i_phase,
  input  alu_cmd_t     i_cmd,
  input  field_state_t i_field,
  input  operand_t     i_operand,
  output result_t      o_result
);

  nibble_t                    res1_q;
  nibble_t                    res2_q;
  logic                       carry_q;
  logic                       nz_q;
  logic                       cin;
  logic [`SATURN_NIBBLE_W:0]  sum;
  nibble_t                    res1_n;
  nibble_t                    res2_n;

  // first digit seeds the chain, 1 turns the inversion into a negation
  assign cin = i_field.is_first ? (i_cmd.op == ALU_OP_2CMPL) : carry_q;

  always_comb begin
    sum    = '0;
    res1_n = '0;
    res2_n = '0;
    case (i_cmd.op)
      ALU_OP_COPY: res1_n = i_operand.src1;
      ALU_OP_EXCH: begin
        res1_n = i_operand.src2;
        res2_n = i_operand.src1;
      end
      ALU_OP_ADD: begin
        sum    = i_operand.src1 + i_operand.src2 + cin;
        res1_n = sum[`SATURN_NIBBLE_W-1:0];
      end
      ALU_OP_2CMPL: begin
        sum    = {1'b0, ~i_operand.src1} + cin;
        res1_n = sum[`SATURN_NIBBLE_W-1:0];
      end
      ALU_OP_CLR_MASK: res1_n = i_operand.src1 & ~i_operand.src2;
      default: res1_n = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_phase.calc) begin
      res1_q <= res1_n;
      res2_q <= res2_n;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      carry_q <= 1'b0;
      nz_q    <= 1'b0;
    end else if (i_phase.calc) begin
      if ((i_cmd.op == ALU_OP_ADD) || (i_cmd.op == ALU_OP_2CMPL)) begin
        carry_q <= sum[`SATURN_NIBBLE_W];
      end
      // sticky over the field, restarted on its first digit
      nz_q <= (res1_n != '0) || (!i_field.is_first && nz_q);
    end
  end

  assign o_result.res1  = res1_q;
  assign o_result.res2  = res2_q;
  assign o_result.carry = (i_cmd.op == ALU_OP_2CMPL) ? nz_q : carry_q;

endmodule

`default_nettype wire

// ==== saturn_alu_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "saturn_alu_settings.svh"

module saturn_alu_regfile
  import saturn_alu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset,
  input  phase_t       i_phase,
  input  alu_cmd_t     i_cmd,
  input  field_state_t i_field,
  input  result_t      i_result,
  input  alu_reg_e     i_rd_sel,
  output reg_view_t    o_regs,
  output word_t        o_rd_data,
  output logic         o_carry
);

  localparam int NW = `SATURN_NIBBLE_W;

  word_t                                           reg_a;
  word_t                                           reg_b;
  word_t                                           reg_c;
  word_t                                           reg_d;
  logic [`SATURN_NIBBLE_W*`SATURN_ADDR_NIBBLES-1:0] reg_d0;
  logic [`SATURN_NIBBLE_W*`SATURN_ADDR_NIBBLES-1:0] reg_d1;
  logic                                            carry_q;
  logic                                            addr_ok;

  // address registers only hold the low digits
  assign addr_ok = (i_field.cur < `SATURN_ADDR_NIBBLES);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      reg_a   <= '0;
      reg_b   <= '0;
      reg_c   <= '0;
      reg_d   <= '0;
      reg_d0  <= '0;
      reg_d1  <= '0;
      carry_q <= 1'b0;
    end else if (i_phase.save) begin
      case (i_cmd.dest)
        ALU_REG_A: reg_a[i_field.cur*NW +: NW] <= i_result.res1;
        ALU_REG_B: reg_b[i_field.cur*NW +: NW] <= i_result.res1;
        ALU_REG_C: reg_c[i_field.cur*NW +: NW] <= i_result.res1;
        ALU_REG_D: reg_d[i_field.cur*NW +: NW] <= i_result.res1;
        ALU_REG_D0: begin
          if (addr_ok) begin
            reg_d0[i_field.cur*NW +: NW] <= i_result.res1;
          end
        end
        ALU_REG_D1: begin
          if (addr_ok) begin
            reg_d1[i_field.cur*NW +: NW] <= i_result.res1;
          end
        end
        default: ;
      endcase
      // second half of an exchange goes back into src2
      if (i_cmd.op == ALU_OP_EXCH) begin
        case (i_cmd.src2)
          ALU_REG_A: reg_a[i_field.cur*NW +: NW] <= i_result.res2;
          ALU_REG_B: reg_b[i_field.cur*NW +: NW] <= i_result.res2;
          ALU_REG_C: reg_c[i_field.cur*NW +: NW] <= i_result.res2;
          ALU_REG_D: reg_d[i_field.cur*NW +: NW] <= i_result.res2;
          default: ;
        endcase
      end
      if (i_field.is_last) begin
        if ((i_cmd.op == ALU_OP_ADD) || (i_cmd.op == ALU_OP_2CMPL)) begin
          carry_q <= i_result.carry;
        end
      end
    end
  end

  always_comb begin
    case (i_rd_sel)
      ALU_REG_A:  o_rd_data = reg_a;
      ALU_REG_B:  o_rd_data = reg_b;
      ALU_REG_C:  o_rd_data = reg_c;
      ALU_REG_D:  o_rd_data = reg_d;
      ALU_REG_D0: o_rd_data = word_t'(reg_d0);
      ALU_REG_D1: o_rd_data = word_t'(reg_d1);
      default:    o_rd_data = '0;
    endcase
  end

  assign o_regs  = '{reg_a, reg_b, reg_c, reg_d, reg_d0, reg_d1};
  assign o_carry = carry_q;

endmodule

`default_nettype wire

// ==== saturn_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module saturn_alu
  import saturn_alu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_en_alu_init,
  input  logic       i_en_alu_prep,
  input  logic       i_en_alu_calc,
  input  logic       i_en_alu_save,
  input  logic       i_ins_alu_op,
  input  alu_op_e    i_alu_op,
  input  alu_reg_e   i_reg_dest,
  input  alu_reg_e   i_reg_src1,
  input  alu_reg_e   i_reg_src2,
  input  field_idx_t i_field_start,
  input  field_idx_t i_field_last,
  input  nibble_t    i_imm_value,
  input  alu_reg_e   i_rd_sel,
  output logic       o_busy,
  output word_t      o_rd_data,
  output logic       o_carry
);

  alu_cmd_t     cmd;
  field_state_t field;
  phase_t       phase;
  reg_view_t    regs;
  operand_t     operand;
  result_t      result;

  saturn_alu_cmd_latch u_cmd_latch (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_alu_init (i_en_alu_init),
    .i_en_alu_prep (i_en_alu_prep),
    .i_en_alu_calc (i_en_alu_calc),
    .i_en_alu_save (i_en_alu_save),
    .i_ins_alu_op  (i_ins_alu_op),
    .i_alu_op      (i_alu_op),
    .i_reg_dest    (i_reg_dest),
    .i_reg_src1    (i_reg_src1),
    .i_reg_src2    (i_reg_src2),
    .i_field_start (i_field_start),
    .i_field_last  (i_field_last),
    .o_cmd         (cmd),
    .o_field       (field),
    .o_phase       (phase),
    .o_busy        (o_busy)
  );

  saturn_alu_operand_fetch u_operand_fetch (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_phase     (phase),
    .i_cmd       (cmd),
    .i_field     (field),
    .i_regs      (regs),
    .i_imm_value (i_imm_value),
    .o_operand   (operand)
  );

  saturn_alu_nibble_calc u_nibble_calc (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_phase   (phase),
    .i_cmd     (cmd),
    .i_field   (field),
    .i_operand (operand),
    .o_result  (result)
  );

  saturn_alu_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_phase   (phase),
    .i_cmd     (cmd),
    .i_field   (field),
    .i_result  (result),
    .i_rd_sel  (i_rd_sel),
    .o_regs    (regs),
    .o_rd_data (o_rd_data),
    .o_carry   (o_carry)
  );

endmodule

`default_nettype wire

// ==== saturn_alu_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module saturn_alu_assertions (
  input logic i_clk,
  input logic i_reset,
  input logic i_init,
  input logic i_prep,
  input logic i_calc,
  input logic i_save,
  input logic i_busy,
  input logic i_carry
);

  busy_low_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_busy)
    else $error("o_busy is high in the cycle after reset");

  // the decoder issues at most one phase strobe per cycle
  one_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({i_init, i_prep, i_calc, i_save}))
    else $error("more than one strobe in the same cycle");

  carry_after_save: assert property (@(posedge i_clk) disable iff (i_reset)
    $changed(i_carry) |-> $past(i_save && i_busy))
    else $error("o_carry changed without a save in the previous cycle");

endmodule

bind saturn_alu saturn_alu_assertions u_assertions (
  .i_clk   (i_clk),
  .i_reset (i_reset),
  .i_init  (i_en_alu_init),
  .i_prep  (i_en_alu_prep),
  .i_calc  (i_en_alu_calc),
  .i_save  (i_en_alu_save),
  .i_busy  (o_busy),
  .i_carry (o_carry)
);

`default_nettype wire

// ==== tb_saturn_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "saturn_alu_settings.svh"

module tb_saturn_alu
  import saturn_alu_pkg::*;
();

  localparam int NW         = `SATURN_NIBBLE_W;
  localparam int WAIT_LIMIT = 40;

  logic       clk;
  logic       reset;
  logic       en_init;
  logic       en_prep;
  logic       en_calc;
  logic       en_save;
  logic       ins_alu_op;
  alu_op_e    alu_op;
  alu_reg_e   reg_dest;
  alu_reg_e   reg_src1;
  alu_reg_e   reg_src2;
  field_idx_t field_start;
  field_idx_t field_last;
  nibble_t    imm_value;
  alu_reg_e   rd_sel;
  logic       busy;
  word_t      rd_data;
  logic       carry;

  // expected register contents indexed by the register select
  word_t       exp_reg [0:5];
  logic        exp_carry;
  nibble_t     imm_nibs [0:15];
  logic [31:0] lfsr_q;

  saturn_alu dut0 (
    .i_clk         (clk),
    .i_reset       (reset),
    .i_en_alu_init (en_init),
    .i_en_alu_prep (en_prep),
    .i_en_alu_calc (en_calc),
    .i_en_alu_save (en_save),
    .i_ins_alu_op  (ins_alu_op),
    .i_alu_op      (alu_op),
    .i_reg_dest    (reg_dest),
    .i_reg_src1    (reg_src1),
    .i_reg_src2    (reg_src2),
    .i_field_start (field_start),
    .i_field_last  (field_last),
    .i_imm_value   (imm_value),
    .i_rd_sel      (rd_sel),
    .o_busy        (busy),
    .o_rd_data     (rd_data),
    .o_carry       (carry)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois LFSR stepped once per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic nibble_t rand_nibble();
    nibble_t n;
    n = '0;
    for (int k = 0; k < NW; k++) begin
      n = {n[NW-2:0], lfsr_bit()};
    end
    return n;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int k = 0; k < `SATURN_WORD_NIBBLES; k++) begin
      w = {w[NW*(`SATURN_WORD_NIBBLES-1)-1:0], rand_nibble()};
    end
    return w;
  endfunction

  function automatic int field_len(input field_idx_t first, input field_idx_t last);
    field_idx_t d;
    d = last - first;
    return int'(d) + 1;
  endfunction

  // gathers the field digits into the low end and wraps past nibble 15
  function automatic word_t get_field(input word_t w, input field_idx_t first, input int len);
    word_t v;
    int    idx;
    v = '0;
    for (int k = 0; k < len; k++) begin
      idx = (int'(first) + k) % `SATURN_WORD_NIBBLES;
      v[k*NW +: NW] = w[idx*NW +: NW];
    end
    return v;
  endfunction

  // D0 and D1 keep only their low digits while IMM and ZERO keep nothing
  function automatic void model_write(input alu_reg_e sel, input int idx, input nibble_t n);
    if ((sel <= ALU_REG_D) || ((sel <= ALU_REG_D1) && (idx < `SATURN_ADDR_NIBBLES))) begin
      exp_reg[sel][idx*NW +: NW] = n;
    end
  endfunction

  function automatic void apply_field(input alu_reg_e sel, input field_idx_t first,
                                      input int len, input word_t v);
    for (int k = 0; k < len; k++) begin
      model_write(sel, (int'(first) + k) % `SATURN_WORD_NIBBLES, v[k*NW +: NW]);
    end
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_carry(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_state();
    alu_reg_e sel;
    for (int i = 0; i < 6; i++) begin
      sel    = alu_reg_e'(i);
      rd_sel = sel;
      #1;
      compare_word(sel.name(), rd_data, exp_reg[sel]);
    end
    compare_carry("o_carry", carry, exp_carry);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy) begin
      if (n == WAIT_LIMIT) begin
        abort_run("timeout: o_busy did not fall after the last save");
      end
      step();
      n++;
    end
  endtask

  // one init and then prep, calc and save per digit
  // intrude sends a stray init in the middle of the run
  task automatic issue_op(input alu_op_e op, input alu_reg_e dest, input alu_reg_e src1,
                          input alu_reg_e src2, input field_idx_t first,
                          input field_idx_t last, input bit intrude);
    int n;
    n = field_len(first, last);
    step();
    en_init     = 1'b1;
    ins_alu_op  = 1'b1;
    alu_op      = op;
    reg_dest    = dest;
    reg_src1    = src1;
    reg_src2    = src2;
    field_start = first;
    field_last  = last;
    step();
    en_init    = 1'b0;
    ins_alu_op = 1'b0;
    compare_carry("o_busy", busy, 1'b1);
    for (int k = 0; k < n; k++) begin
      imm_value = imm_nibs[k];
      en_prep   = 1'b1;
      step();
      en_prep = 1'b0;
      en_calc = 1'b1;
      step();
      en_calc = 1'b0;
      en_save = 1'b1;
      step();
      en_save = 1'b0;
      if (intrude && (k == 0)) begin
        en_init     = 1'b1;
        ins_alu_op  = 1'b1;
        alu_op      = ALU_OP_ZERO;
        reg_dest    = ALU_REG_A;
        field_start = 4'd0;
        field_last  = 4'd15;
        step();
        en_init    = 1'b0;
        ins_alu_op = 1'b0;
      end
    end
    wait_idle();
  endtask

  task automatic load_reg(input alu_reg_e sel, input word_t val, input field_idx_t first,
                          input field_idx_t last);
    int n;
    n = field_len(first, last);
    for (int k = 0; k < n; k++) begin
      imm_nibs[k] = val[((int'(first) + k) % `SATURN_WORD_NIBBLES)*NW +: NW];
    end
    issue_op(ALU_OP_COPY, sel, ALU_REG_IMM, ALU_REG_ZERO, first, last, 1'b0);
    apply_field(sel, first, n, get_field(val, first, n));
  endtask

  task automatic after_reset();
    compare_carry("o_busy", busy, 1'b0);
    check_state();
  endtask

  task automatic copy_from_imm();
    load_reg(ALU_REG_A, rand_word(), 4'd0, 4'd15);
    check_state();
    load_reg(ALU_REG_A, rand_word(), 4'd3, 4'd6);
    check_state();
    load_reg(ALU_REG_A, rand_word(), 4'd14, 4'd1);
    check_state();
  endtask

  task automatic add_with_carry();
    field_idx_t  first;
    field_idx_t  last;
    int          n;
    logic [64:0] sum;
    for (int r = 0; r < 3; r++) begin
      load_reg(ALU_REG_A, rand_word(), 4'd0, 4'd15);
      load_reg(ALU_REG_B, rand_word(), 4'd0, 4'd15);
      load_reg(ALU_REG_C, rand_word(), 4'd0, 4'd15);
      first = rand_nibble();
      last  = rand_nibble();
      n     = field_len(first, last);
      sum   = {1'b0, get_field(exp_reg[ALU_REG_A], first, n)} +
              {1'b0, get_field(exp_reg[ALU_REG_B], first, n)};
      // overflow is the bit just above the top digit of the field
      apply_field(ALU_REG_C, first, n, sum[63:0]);
      exp_carry = sum[n*NW];
      issue_op(ALU_OP_ADD, ALU_REG_C, ALU_REG_A, ALU_REG_B, first, last, 1'b0);
      check_state();
    end
  endtask

  task automatic negate_mask_and_clear();
    field_idx_t first;
    field_idx_t last;
    int         n;
    word_t      fa;
    first = rand_nibble();
    last  = rand_nibble();
    n     = field_len(first, last);
    load_reg(ALU_REG_A, rand_word(), 4'd0, 4'd15);
    fa = get_field(exp_reg[ALU_REG_A], first, n);
    apply_field(ALU_REG_D, first, n, word_t'(0) - fa);
    exp_carry = (fa != '0);
    issue_op(ALU_OP_2CMPL, ALU_REG_D, ALU_REG_A, ALU_REG_ZERO, first, last, 1'b0);
    check_state();
    // a zero field negates to zero with CARRY clear
    load_reg(ALU_REG_A, '0, first, last);
    apply_field(ALU_REG_D, first, n, '0);
    exp_carry = 1'b0;
    issue_op(ALU_OP_2CMPL, ALU_REG_D, ALU_REG_A, ALU_REG_ZERO, first, last, 1'b0);
    check_state();
    load_reg(ALU_REG_B, rand_word(), 4'd0, 4'd15);
    first = rand_nibble();
    last  = rand_nibble();
    n     = field_len(first, last);
    apply_field(ALU_REG_C, first, n, get_field(exp_reg[ALU_REG_A], first, n) &
                ~get_field(exp_reg[ALU_REG_B], first, n));
    issue_op(ALU_OP_CLR_MASK, ALU_REG_C, ALU_REG_A, ALU_REG_B, first, last, 1'b0);
    check_state();
    first = rand_nibble();
    last  = rand_nibble();
    apply_field(ALU_REG_B, first, field_len(first, last), '0);
    issue_op(ALU_OP_ZERO, ALU_REG_B, ALU_REG_ZERO, ALU_REG_ZERO, first, last, 1'b0);
    check_state();
  endtask

  task automatic exchange_and_write_rules();
    field_idx_t first;
    field_idx_t last;
    int         n;
    word_t      fa;
    word_t      fb;
    load_reg(ALU_REG_B, rand_word(), 4'd0, 4'd15);
    first = rand_nibble();
    last  = rand_nibble();
    n     = field_len(first, last);
    fa    = get_field(exp_reg[ALU_REG_A], first, n);
    fb    = get_field(exp_reg[ALU_REG_B], first, n);
    apply_field(ALU_REG_A, first, n, fb);
    apply_field(ALU_REG_B, first, n, fa);
    issue_op(ALU_OP_EXCH, ALU_REG_A, ALU_REG_A, ALU_REG_B, first, last, 1'b0);
    check_state();
    load_reg(ALU_REG_D1, rand_word(), 4'd0, 4'd15);
    check_state();
    // a stray init after the first save must leave the copy untouched
    first = rand_nibble();
    last  = first + 4'd5;
    fa    = get_field(exp_reg[ALU_REG_A], first, 6);
    apply_field(ALU_REG_C, first, 6, fa);
    issue_op(ALU_OP_COPY, ALU_REG_C, ALU_REG_A, ALU_REG_ZERO, first, last, 1'b1);
    check_state();
  endtask

  initial begin
    lfsr_q      = 32'he005_701b;
    reset       = 1'b1;
    en_init     = 1'b0;
    en_prep     = 1'b0;
    en_calc     = 1'b0;
    en_save     = 1'b0;
    ins_alu_op  = 1'b0;
    alu_op      = ALU_OP_ZERO;
    reg_dest    = ALU_REG_A;
    reg_src1    = ALU_REG_ZERO;
    reg_src2    = ALU_REG_ZERO;
    field_start = '0;
    field_last  = '0;
    imm_value   = '0;
    rd_sel      = ALU_REG_A;
    exp_carry   = 1'b0;
    for (int i = 0; i < 6; i++) begin
      exp_reg[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      imm_nibs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    step();
    after_reset();
    copy_from_imm();
    add_with_carry();
    negate_mask_and_clear();
    exchange_and_write_rules();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== saturn_alu.f ====
+incdir+.
saturn_alu_pkg.sv
saturn_alu_cmd_latch.sv
saturn_alu_operand_fetch.sv
saturn_alu_nibble_calc.sv
saturn_alu_regfile.sv
saturn_alu.sv
saturn_alu_assertions.sv
tb_saturn_alu.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the saturn_alu testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_saturn_alu \
  -f saturn_alu.f -Mdir obj_dir > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_saturn_alu > sim.log 2>&1 || true
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation PASSED"
exit 0
